// File: Bender.yml
package:
  name: qpll_reset

sources:
  - target: any(rtl, test)
    include_dirs:
      - src
    files:
      - src/qpll_rst_pkg.sv
      - src/qpll_status_sync.sv
      - src/qpll_reset_fsm.sv
      - src/qpll_drp_seq.sv
      - src/qpll_reset_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/qpll_reset_assert.sv
      - testbench/qpll_reset_tb.sv

// File: filelist.f
+incdir+src
src/qpll_rst_pkg.sv
src/qpll_status_sync.sv
src/qpll_reset_fsm.sv
src/qpll_drp_seq.sv
src/qpll_reset_top.sv
testbench/qpll_reset_assert.sv
testbench/qpll_reset_tb.sv

// File: src/qpll_drp_seq.sv
`timescale 1ns/1ps
`include "qpll_rst_macros.svh"

module qpll_drp_seq
    import qpll_rst_pkg::*;
(
    input  logic      QRST_CLK,
    input  logic      QRST_RST_N,
    input  logic      drp_start,
    input  logic      ovrd,
    input  quad_vec_t drp_rdy,
    output quad_vec_t drp_en,
    output quad_vec_t drp_we,
    output drp_addr_t drp_addr,
    output drp_data_t drp_di,
    output quad_vec_t drp_done
);

    typedef enum logic [1:0] {
        seq_inactive,
        seq_issue,
        seq_wait
    } seq_state_t;

    typedef logic [$clog2(`QRST_DRP_ENTRIES)-1:0] entry_idx_t;

    seq_state_t seq_state;
    entry_idx_t idx;
    logic       opt_sel;     // Latched ovrd for the whole pass
    quad_vec_t  ack_mask;
    quad_vec_t  ack_next;
    logic       last_entry;

    // Fbdiv, coarse frequency override, lock config
    function automatic drp_addr_t table_addr(input entry_idx_t i);
        case (i)
            0:       return 9'h036;
            1:       return 9'h035;
            default: return 9'h034;
        endcase
    endfunction

    function automatic drp_data_t table_data(input logic opt, input entry_idx_t i);
        case (i)
            0:       return 16'h0160;
            1:       return opt ? 16'h8220 : 16'h0000;  // Override enable plus coarse code
            default: return opt ? 16'h21e8 : 16'h01e8;
        endcase
    endfunction

    // A fresh entry starts with an empty mask
    assign ack_next   = (seq_state == seq_issue) ? drp_rdy : (ack_mask | drp_rdy);
    assign last_entry = (idx == entry_idx_t'(`QRST_DRP_ENTRIES - 1));

    always_ff @(posedge QRST_CLK)
    begin
        if (!QRST_RST_N)
        begin
            seq_state <= seq_inactive;
            idx       <= '0;
            opt_sel   <= 1'b0;
            ack_mask  <= '0;
            drp_done  <= '1;
        end
        else
        begin
            case (seq_state)
                seq_inactive:
                begin
                    if (drp_start)
                    begin
                        opt_sel   <= ovrd;
                        idx       <= '0;
                        drp_done  <= '0;
                        seq_state <= seq_issue;
                    end
                end
                seq_issue, seq_wait:
                begin
                    if (last_entry)
                        drp_done <= ack_next;  // Quad done once it acks the final write
                    if (&ack_next)
                    begin
                        ack_mask <= '0;
                        if (last_entry)
                            seq_state <= seq_inactive;
                        else
                        begin
                            idx       <= idx + 1'b1;
                            seq_state <= seq_issue;
                        end
                    end
                    else
                    begin
                        ack_mask  <= ack_next;
                        seq_state <= seq_wait;
                    end
                end
                default: seq_state <= seq_inactive;
            endcase
        end
    end

    // Same write broadcast to every quad
    assign drp_en   = {`QRST_QUADS{seq_state == seq_issue}};
    assign drp_we   = drp_en;
    assign drp_addr = table_addr(idx);
    assign drp_di   = table_data(opt_sel, idx);

endmodule

// File: src/qpll_reset_fsm.sv
`timescale 1ns/1ps
`include "qpll_rst_macros.svh"

module qpll_reset_fsm
    import qpll_rst_pkg::*;
(
    input  logic        QRST_CLK,
    input  logic        QRST_RST_N,
    input  logic        mmcm_lock_s,
    input  lane_vec_t   cplllock_s,
    input  quad_vec_t   qplllock_s,
    input  rate_t       rate_s,
    input  lane_vec_t   qpllreset_in_s,
    input  lane_vec_t   qpllpd_in_s,
    input  quad_vec_t   drp_done,
    output logic        ovrd,
    output logic        drp_start,
    output logic        qpllreset,
    output logic        qpllpd,
    output logic        idle,
    output qrst_state_t state
);

    logic qpllpd_r;
    logic cpll_pd_req;  // QPLL unused by the lanes at this rate

    assign cpll_pd_req = (`QRST_PLL_SEL_QPLL == 0) && (rate_s != 2'd2);

    always_ff @(posedge QRST_CLK)
    begin
        if (!QRST_RST_N)
        begin
            state     <= qrst_wait_lock;
            ovrd      <= 1'b0;
            qpllreset <= 1'b1;
            qpllpd_r  <= 1'b0;
        end
        else
        begin
            case (state)
                qrst_idle:
                begin
                    // Lanes share one QPLL, so all of them must ask
                    qpllreset <= &qpllreset_in_s;
                    qpllpd_r  <= &qpllpd_in_s;
                end
                qrst_wait_lock:
                begin
                    if ((cplllock_s == '0) && (qplllock_s == '0))
                        state <= qrst_mmcm_lock;
                end
                qrst_mmcm_lock:
                begin
                    if (mmcm_lock_s && (&cplllock_s))
                        state <= qrst_drp_start_nom;
                end
                qrst_drp_start_nom:
                begin
                    if (drp_done == '0)
                        state <= qrst_drp_done_nom;
                end
                qrst_drp_done_nom:
                begin
                    if (&drp_done)
                        state <= qrst_qplllock;
                end
                qrst_qplllock:
                begin
                    qpllreset <= 1'b0;
                    if (&qplllock_s)
                    begin
                        if (`QRST_BYPASS_COARSE != 0)
                            state <= qrst_qpll_pdreset;
                        else
                        begin
                            state <= qrst_drp_start_opt;
                            ovrd  <= 1'b1;  // Valid before the sequencer samples start
                        end
                    end
                end
                qrst_drp_start_opt:
                begin
                    ovrd <= 1'b1;
                    if (drp_done == '0)
                        state <= qrst_drp_done_opt;
                end
                qrst_drp_done_opt:
                begin
                    if (&drp_done)
                    begin
                        qpllreset <= (`QRST_PLL_SEL_QPLL != 0);
                        if (`QRST_PLL_SEL_QPLL != 0)
                            state <= qrst_qpll_reset;
                        else
                            state <= qrst_qpll_pdreset;
                    end
                end
                qrst_qpll_reset:
                begin
                    qpllreset <= 1'b1;
                    qpllpd_r  <= 1'b0;
                    if (qplllock_s == '0)
                        state <= qrst_qplllock2;
                end
                qrst_qplllock2:
                begin
                    qpllreset <= 1'b0;
                    qpllpd_r  <= 1'b0;
                    if (&qplllock_s)
                        state <= qrst_idle;
                end
                qrst_qpll_pdreset:
                begin
                    qpllreset <= cpll_pd_req;
                    state     <= qrst_qpll_pd;
                end
                qrst_qpll_pd:
                begin
                    qpllpd_r <= cpll_pd_req;  // Power down one cycle after reset
                    state    <= qrst_idle;
                end
                default:
                begin
                    state     <= qrst_wait_lock;
                    ovrd      <= 1'b0;
                    qpllreset <= 1'b0;
                    qpllpd_r  <= 1'b0;
                end
            endcase
        end
    end

    assign drp_start = (state == qrst_drp_start_nom) || (state == qrst_drp_start_opt);
    assign idle      = (state == qrst_idle);
    assign qpllpd    = (`QRST_POWER_SAVING != 0) ? qpllpd_r : 1'b0;

endmodule

// File: src/qpll_reset_top.sv
`timescale 1ns/1ps

module qpll_reset_top
    import qpll_rst_pkg::*;
(
    input  logic        QRST_CLK,
    input  logic        QRST_RST_N,
    input  logic        mmcm_lock,
    input  lane_vec_t   cplllock,
    input  quad_vec_t   qplllock,
    input  rate_t       rate,
    input  lane_vec_t   qpllreset_in,
    input  lane_vec_t   qpllpd_in,
    input  quad_vec_t   drp_rdy,
    output logic        ovrd,
    output logic        qpllreset,
    output logic        qpllpd,
    output logic        idle,
    output qrst_state_t state,
    output quad_vec_t   drp_en,
    output quad_vec_t   drp_we,
    output drp_addr_t   drp_addr,
    output drp_data_t   drp_di
);

    logic      mmcm_lock_s;
    lane_vec_t cplllock_s;
    quad_vec_t qplllock_s;
    rate_t     rate_s;
    lane_vec_t qpllreset_in_s;
    lane_vec_t qpllpd_in_s;
    logic      drp_start;
    quad_vec_t drp_done;    // Already in the clock domain, no sync

    qpll_status_sync sync_i (
        .QRST_CLK       (QRST_CLK),
        .QRST_RST_N     (QRST_RST_N),
        .mmcm_lock      (mmcm_lock),
        .cplllock       (cplllock),
        .qplllock       (qplllock),
        .rate           (rate),
        .qpllreset_in   (qpllreset_in),
        .qpllpd_in      (qpllpd_in),
        .mmcm_lock_s    (mmcm_lock_s),
        .cplllock_s     (cplllock_s),
        .qplllock_s     (qplllock_s),
        .rate_s         (rate_s),
        .qpllreset_in_s (qpllreset_in_s),
        .qpllpd_in_s    (qpllpd_in_s)
    );

    qpll_reset_fsm fsm_i (
        .QRST_CLK       (QRST_CLK),
        .QRST_RST_N     (QRST_RST_N),
        .mmcm_lock_s    (mmcm_lock_s),
        .cplllock_s     (cplllock_s),
        .qplllock_s     (qplllock_s),
        .rate_s         (rate_s),
        .qpllreset_in_s (qpllreset_in_s),
        .qpllpd_in_s    (qpllpd_in_s),
        .drp_done       (drp_done),
        .ovrd           (ovrd),
        .drp_start      (drp_start),
        .qpllreset      (qpllreset),
        .qpllpd         (qpllpd),
        .idle           (idle),
        .state          (state)
    );

    qpll_drp_seq drp_i (
        .QRST_CLK   (QRST_CLK),
        .QRST_RST_N (QRST_RST_N),
        .drp_start  (drp_start),
        .ovrd       (ovrd),
        .drp_rdy    (drp_rdy),
        .drp_en     (drp_en),
        .drp_we     (drp_we),
        .drp_addr   (drp_addr),
        .drp_di     (drp_di),
        .drp_done   (drp_done)
    );

endmodule

// File: src/qpll_rst_macros.svh
`ifndef QPLL_RST_MACROS_SVH
`define QPLL_RST_MACROS_SVH

// Lane geometry
`define QRST_LANES 8

// One quad serves up to four lanes
`define QRST_QUADS (((`QRST_LANES - 1) >> 2) + 1)

// Lanes clocked from the QPLL when 1, from the channel PLL when 0
`define QRST_PLL_SEL_QPLL 1

`define QRST_POWER_SAVING 1  // Let the power-down output through

// Skip the optimized DRP pass and go straight to the power-down path
`define QRST_BYPASS_COARSE 0

`define QRST_DRP_ENTRIES 3  // Writes per DRP pass

`endif

// File: src/qpll_rst_pkg.sv
`include "qpll_rst_macros.svh"

package qpll_rst_pkg;

    // Sequencer states, numbered as in the original reset block
    typedef enum logic [3:0] {
        qrst_idle          = 4'd1,
        qrst_wait_lock     = 4'd2,
        qrst_mmcm_lock     = 4'd3,
        qrst_drp_start_nom = 4'd4,
        qrst_drp_done_nom  = 4'd5,
        qrst_qplllock      = 4'd6,
        qrst_drp_start_opt = 4'd7,
        qrst_drp_done_opt  = 4'd8,
        qrst_qpll_reset    = 4'd9,
        qrst_qplllock2     = 4'd10,
        qrst_qpll_pdreset  = 4'd11,
        qrst_qpll_pd       = 4'd12
    } qrst_state_t;

    typedef logic [`QRST_LANES-1:0] lane_vec_t;
    typedef logic [`QRST_QUADS-1:0] quad_vec_t;
    typedef logic [1:0]             rate_t;      // Code 2 keeps QPLL up in CPLL mode
    typedef logic [8:0]             drp_addr_t;
    typedef logic [15:0]            drp_data_t;

endpackage

// File: src/qpll_status_sync.sv
`timescale 1ns/1ps

module qpll_status_sync
    import qpll_rst_pkg::*;
(
    input  logic      QRST_CLK,
    input  logic      QRST_RST_N,
    input  logic      mmcm_lock,
    input  lane_vec_t cplllock,
    input  quad_vec_t qplllock,
    input  rate_t     rate,
    input  lane_vec_t qpllreset_in,
    input  lane_vec_t qpllpd_in,
    output logic      mmcm_lock_s,
    output lane_vec_t cplllock_s,
    output quad_vec_t qplllock_s,
    output rate_t     rate_s,
    output lane_vec_t qpllreset_in_s,
    output lane_vec_t qpllpd_in_s
);

    // First stage, may go metastable
    logic      mmcm_lock_m;
    lane_vec_t cplllock_m;
    quad_vec_t qplllock_m;
    rate_t     rate_m;
    lane_vec_t qpllreset_in_m;
    lane_vec_t qpllpd_in_m;

    always_ff @(posedge QRST_CLK)
    begin
        if (!QRST_RST_N)
        begin
            mmcm_lock_m    <= 1'b0;
            cplllock_m     <= '1;  // Held high so the FSM first sees the locks drop
            qplllock_m     <= '0;
            rate_m         <= 2'd0;
            qpllreset_in_m <= '1;
            qpllpd_in_m    <= '0;
            mmcm_lock_s    <= 1'b0;
            cplllock_s     <= '1;
            qplllock_s     <= '0;
            rate_s         <= 2'd0;
            qpllreset_in_s <= '1;
            qpllpd_in_s    <= '0;
        end
        else
        begin
            mmcm_lock_m    <= mmcm_lock;
            cplllock_m     <= cplllock;
            qplllock_m     <= qplllock;
            rate_m         <= rate;
            qpllreset_in_m <= qpllreset_in;
            qpllpd_in_m    <= qpllpd_in;
            mmcm_lock_s    <= mmcm_lock_m;
            cplllock_s     <= cplllock_m;
            qplllock_s     <= qplllock_m;
            rate_s         <= rate_m;
            qpllreset_in_s <= qpllreset_in_m;
            qpllpd_in_s    <= qpllpd_in_m;
        end
    end

endmodule

// File: testbench/qpll_reset_assert.sv
`timescale 1ns/1ps

module qpll_reset_assert
    import qpll_rst_pkg::*;
(
    input logic      QRST_CLK,
    input logic      QRST_RST_N,
    input logic      idle,
    input logic      ovrd,
    input quad_vec_t drp_en,
    input quad_vec_t drp_rdy
);

    int unsigned fail_count = 0;
    quad_vec_t   pending;  // Quads that still owe a drp_rdy

    always_ff @(posedge QRST_CLK)
    begin
        if (!QRST_RST_N)
            pending <= '0;
        else
            pending <= (pending & ~drp_rdy) | drp_en;
    end

    idle_no_write: assert property (@(posedge QRST_CLK) disable iff (!QRST_RST_N)
        !(idle && (drp_en != '0)))
    else
    begin
        $error("DRP write issued while idle");
        fail_count++;
    end

    en_single_pulse: assert property (@(posedge QRST_CLK) disable iff (!QRST_RST_N)
        (drp_en != '0) |=> (drp_en == '0))
    else
    begin
        $error("drp_en held longer than one cycle");
        fail_count++;
    end

    ovrd_sticky: assert property (@(posedge QRST_CLK) disable iff (!QRST_RST_N)
        ovrd |=> ovrd)
    else
    begin
        $error("ovrd dropped before reset");
        fail_count++;
    end

    no_write_while_pending: assert property (@(posedge QRST_CLK) disable iff (!QRST_RST_N)
        (drp_en != '0) |-> (pending == '0))
    else
    begin
        $error("DRP write issued with an acknowledge outstanding");
        fail_count++;
    end

endmodule

// File: testbench/qpll_reset_tb.sv
`timescale 1ns/1ps
`include "qpll_rst_macros.svh"

module qpll_reset_tb
    import qpll_rst_pkg::*;
();

    localparam int RST_CYCLES  = 3;
    localparam int GATE_CYCLES = 50;
    localparam int CPLL_DELAY  = 20;
    localparam int QPLL_DELAY  = 30;
    localparam int MAX_ACK     = 5;
    localparam int SYNC_LAT    = 2;
    localparam int TABLE_LEN   = 2 * `QRST_DRP_ENTRIES;
    localparam int FOLLOW_ROWS = 6;
    localparam int PASS_MAX    = `QRST_DRP_ENTRIES * (MAX_ACK + 4) + 4;
    localparam int TIMEOUT_CYCLES = 2 * (RST_CYCLES + GATE_CYCLES + CPLL_DELAY
        + 2 * QPLL_DELAY + 2 * PASS_MAX + 8 * SYNC_LAT + 5 * FOLLOW_ROWS);

    logic        QRST_CLK;
    logic        QRST_RST_N;
    logic        mmcm_lock;
    lane_vec_t   cplllock;
    quad_vec_t   qplllock;
    rate_t       rate;
    lane_vec_t   qpllreset_in;
    lane_vec_t   qpllpd_in;
    quad_vec_t   drp_rdy;
    logic        ovrd;
    logic        qpllreset;
    logic        qpllpd;
    logic        idle;
    qrst_state_t state;
    quad_vec_t   drp_en;
    quad_vec_t   drp_we;
    drp_addr_t   drp_addr;
    drp_data_t   drp_di;

    logic        cpll_rst;
    int          cpll_cnt;
    int          qpll_cnt;
    logic [31:0] rng = 32'd10439;
    quad_vec_t   ack_pend = '0;
    logic [2:0]  ack_cnt [`QRST_QUADS];
    quad_vec_t   outstanding = '0;  // Writes not yet answered by drp_rdy
    int          wr_idx = 0;
    int          errors = 0;
    int          checks = 0;
    int          drp_errs = 0;
    int          en_seen = 0;
    int          test_errs;
    int          cycles = 0;
    logic        prev_rst = 1'b0;
    logic        prev_pd = 1'b0;

    // Nominal pass first, then the override pass
    drp_addr_t exp_addr [TABLE_LEN] = '{9'h036, 9'h035, 9'h034, 9'h036, 9'h035, 9'h034};
    drp_data_t exp_data [TABLE_LEN] = '{16'h0160, 16'h0000, 16'h01e8,
                                        16'h0160, 16'h8220, 16'h21e8};
    logic      exp_ovrd [TABLE_LEN] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

    // Per-lane requests and the expected AND of each vector
    lane_vec_t follow_rst_in  [FOLLOW_ROWS] = '{8'hff, 8'h7f, 8'hff, 8'hfe, 8'hff, 8'h00};
    lane_vec_t follow_pd_in   [FOLLOW_ROWS] = '{8'h00, 8'hff, 8'hff, 8'h00, 8'h80, 8'hff};
    logic      follow_exp_rst [FOLLOW_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    logic      follow_exp_pd  [FOLLOW_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};

    qpll_reset_top dut_i (.*);

    bind qpll_reset_top qpll_reset_assert assert_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int mismatches);
        if (mismatches == 0)
            $display("test %-14s ok", name);
        else
            $display("test %-14s failed with %0d mismatches", name, mismatches);
    endtask

    initial
    begin
        QRST_CLK = 1'b0;
        forever #4 QRST_CLK = ~QRST_CLK;
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge QRST_CLK);
            cycles++;
        end
        $display("Timeout: sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Channel PLL and QPLL lock a fixed time after leaving reset
    always @(posedge QRST_CLK)
    begin
        if (!QRST_RST_N || cpll_rst)
        begin
            cpll_cnt <= 0;
            cplllock <= '0;
        end
        else if (cpll_cnt == CPLL_DELAY)
            cplllock <= '1;
        else
            cpll_cnt <= cpll_cnt + 1;
    end

    always @(posedge QRST_CLK)
    begin
        if (!QRST_RST_N || qpllreset)
        begin
            qpll_cnt <= 0;
            qplllock <= '0;
        end
        else if (qpll_cnt == QPLL_DELAY)
            qplllock <= '1;
        else
            qpll_cnt <= qpll_cnt + 1;
    end

    // Each quad answers a write after 0 to 5 idle cycles
    always @(posedge QRST_CLK)
    begin
        logic [2:0] delay;
        for (int q = 0; q < `QRST_QUADS; q++)
        begin
            drp_rdy[q] <= 1'b0;
            if (drp_en[q])
            begin
                rng   = xorshift(rng);
                delay = 3'(rng % 6);
                if (delay == 0)
                    drp_rdy[q] <= 1'b1;
                else
                begin
                    ack_cnt[q]  <= delay - 3'd1;
                    ack_pend[q] <= 1'b1;
                end
            end
            else if (ack_pend[q])
            begin
                if (ack_cnt[q] == 0)
                begin
                    drp_rdy[q]  <= 1'b1;
                    ack_pend[q] <= 1'b0;
                end
                else
                    ack_cnt[q] <= ack_cnt[q] - 3'd1;
            end
        end
    end

    always @(posedge QRST_CLK)
    begin
        int e0;
        e0 = errors;
        if (!QRST_RST_N)
            outstanding = '0;
        else
        begin
            if (drp_en != '0)
            begin
                check_eq("drp_no_outstanding", 0, outstanding);
                check_eq("drp_en_broadcast", quad_vec_t'('1), drp_en);
                check_eq("drp_we", quad_vec_t'('1), drp_we);
                if (wr_idx < TABLE_LEN)
                begin
                    check_eq($sformatf("drp_addr[%0d]", wr_idx), exp_addr[wr_idx], drp_addr);
                    check_eq($sformatf("drp_di[%0d]", wr_idx), exp_data[wr_idx], drp_di);
                    check_eq($sformatf("drp_ovrd[%0d]", wr_idx), exp_ovrd[wr_idx], ovrd);
                end
                else
                begin
                    $display("DRP write %0d issued past the end of the expected table", wr_idx);
                    errors++;
                end
                wr_idx++;
            end
            outstanding = (outstanding & ~drp_rdy) | drp_en;
        end
        drp_errs = drp_errs + (errors - e0);
    end

    initial
    begin
        QRST_RST_N   = 1'b0;
        mmcm_lock    = 1'b0;
        cplllock     = '0;
        qplllock     = '0;
        rate         = 2'd0;
        qpllreset_in = '0;
        qpllpd_in    = '0;
        drp_rdy      = '0;
        cpll_rst     = 1'b1;

        repeat (RST_CYCLES) @(posedge QRST_CLK);
        check_eq("rst_qpllreset", 1, qpllreset);
        check_eq("rst_ovrd", 0, ovrd);
        check_eq("rst_qpllpd", 0, qpllpd);
        check_eq("rst_idle", 0, idle);
        check_eq("rst_drp_en", 0, drp_en);
        check_eq("rst_state", qrst_wait_lock, state);
        QRST_RST_N <= 1'b1;
        report_test("reset_values", errors);

        // Channel PLLs lock while the MMCM is still unlocked
        test_errs = errors;
        while (state !== qrst_mmcm_lock)
            @(posedge QRST_CLK);
        cpll_rst <= 1'b0;
        repeat (GATE_CYCLES)
        begin
            @(posedge QRST_CLK);
            if (drp_en != '0)
                en_seen++;
        end
        check_eq("gate_no_drp_en", 0, en_seen);
        check_eq("gate_state", qrst_mmcm_lock, state);
        mmcm_lock <= 1'b1;
        while (drp_en == '0)
            @(posedge QRST_CLK);
        report_test("lock_gating", errors - drp_errs - test_errs);

        test_errs = errors - drp_errs;
        while (qpllreset !== 1'b0)
            @(posedge QRST_CLK);
        check_eq("seq_writes_at_release", `QRST_DRP_ENTRIES, wr_idx);
        check_eq("seq_ovrd_at_release", 0, ovrd);
        while (qpllreset !== 1'b1)
            @(posedge QRST_CLK);
        check_eq("seq_writes_at_reset", TABLE_LEN, wr_idx);
        check_eq("seq_ovrd_at_reset", 1, ovrd);
        while (qpllreset !== 1'b0)
            @(posedge QRST_CLK);
        check_eq("seq_idle_early", 0, idle);
        while (idle !== 1'b1)
            @(posedge QRST_CLK);
        check_eq("seq_final_state", qrst_idle, state);
        report_test("qpll_sequence", errors - drp_errs - test_errs);

        test_errs = errors;
        check_eq("drp_write_count", TABLE_LEN, wr_idx);
        check_eq("drp_outstanding_end", 0, outstanding);
        report_test("drp_table", drp_errs + errors - test_errs);

        // Output holds for two cycles and changes on the third
        test_errs = errors;
        for (int i = 0; i < FOLLOW_ROWS; i++)
        begin
            @(posedge QRST_CLK);
            qpllreset_in <= follow_rst_in[i];
            qpllpd_in    <= follow_pd_in[i];
            repeat (2) @(posedge QRST_CLK);
            @(negedge QRST_CLK);
            check_eq($sformatf("follow_hold_rst[%0d]", i), prev_rst, qpllreset);
            check_eq($sformatf("follow_hold_pd[%0d]", i), prev_pd, qpllpd);
            prev_rst = follow_exp_rst[i];
            prev_pd  = follow_exp_pd[i] && (`QRST_POWER_SAVING != 0);
            @(negedge QRST_CLK);
            check_eq($sformatf("follow_rst[%0d]", i), prev_rst, qpllreset);
            check_eq($sformatf("follow_pd[%0d]", i), prev_pd, qpllpd);
        end
        report_test("idle_follow", errors - test_errs);

        test_errs = errors;
        check_eq("assertion_failures", 0, dut_i.assert_i.fail_count);
        report_test("assertions", errors - test_errs);

        $display("Done: %0d checks, %0d errors, %0d DRP writes", checks, errors, wr_idx);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
